//--- mipsCpuHarvard.f
+incdir+src
src/mipsPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/executeUnit.sv
src/programCounter.sv
src/mipsCpuHarvard.sv
test/mipsCpuProperties.sv
test/tbMipsCpu.sv

//--- test/cpu_testdata.hex
// Six 64-word blocks: expected v0, stall flag (1 = random clkEnable),
// then program words ending in jr $zero; unlisted words stay zero
// Test 1 register and immediate arithmetic, slt/sltu edge values
@000
8000EDC8 00000000
3C088000 2409FFFF 0109502A 0128582B
340C1234 398CFFFF 318D0FF0 292E0000
2DAFFFFF 01A81023 004A1021 004B1021
004E1021 004F1021 0189C024 00581026
004D1025 00000008
// Test 2 sll, srl, sra on negative and positive words
@040
012321DA 00000000
3C08F0F0 35081234 00084903 00085202
00085B00 340C7ABC 000C68C3 012A1026
004B1021 004D1023 00000008
// Test 3 sw then lw round trip with offsets
@080
DEAD6495 00000000
24080040 3C09DEAD 3529BEEF AD090008
340A5A5A AD0AFFFC 250B000C 8D6CFFFC
250DFFF8 8DAE0004 018E1023 00000008
// Test 4 counting loop, beq skip, jal/jr, j
@0C0
0000002F 00000000
24080005 24020000 24420003 2508FFFF
1500FFFD 10000001 24420100 0FF0000B
00491021 0BF0000E 24420200 3C0ABFC0
03EA4823 03E00008 10400001 00000008
24020000
// Test 5 mult and multu of signed extremes
@100
BFFFFFFF 00000000
3C088000 2409FFFF 01090018 00005012
00005810 01090019 00006010 00006812
01080018 00007010 018E1021 004A1026
004B1021 004D1023 00000008
// Test 6 test 4 program with stalls
@140
0000002F 00000001
24080005 24020000 24420003 2508FFFF
1500FFFD 10000001 24420100 0FF0000B
00491021 0BF0000E 24420200 3C0ABFC0
03EA4823 03E00008 10400001 00000008
24020000

//--- test/tbMipsCpu.sv
// Testbench for the single-cycle MIPS core
// Runs six programs from the testdata image, one 64-word block each
// Block word 0 is the expected v0, word 1 the stall flag, the rest code
// Run from the project root so the data file path resolves
// ROM window is 256 words at the reset vector, RAM is 256 words at 0

`include "mips_config.svh"

module tbMipsCpu
  import mipsPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          clkPeriodNs   = 10;
  localparam int          testCount     = 6;
  localparam int          cyclesPerTest = 400;
  localparam int          blockWords    = 64;
  localparam int          memWords      = 256;
  localparam logic [15:0] lfsrSeed      = 16'd38915;
  localparam word_t       romBase       = `MIPS_RESET_VECTOR;

  logic        clk;
  logic        reset;
  logic        clkEnable;
  logic        active;
  word_t       registerV0;
  word_t       instrAddress;
  word_t       instrReadData;
  word_t       dataAddress;
  logic        dataWrite;
  logic        dataRead;
  word_t       dataWriteData;
  word_t       dataReadData;
  word_t       testData [testCount * blockWords];
  word_t       rom [memWords];
  word_t       ram [memWords];
  logic [15:0] lfsrState;
  int          errorCount;
  int          failedTests;

  mipsCpuHarvard u_mipsCpuHarvard (
    .clk           (clk),
    .reset         (reset),
    .clkEnable     (clkEnable),
    .active        (active),
    .registerV0    (registerV0),
    .instrAddress  (instrAddress),
    .instrReadData (instrReadData),
    .dataAddress   (dataAddress),
    .dataWrite     (dataWrite),
    .dataRead      (dataRead),
    .dataWriteData (dataWriteData),
    .dataReadData  (dataReadData)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  // Instruction ROM, reads zero (nop) outside its window
  assign instrReadData = (instrAddress[31:10] == romBase[31:10]) ?
                         rom[instrAddress[9:2]] : '0;

  // Data RAM, read data only driven while dataRead is high
  assign dataReadData = dataRead ? ram[dataAddress[9:2]] : 'x;

  // Write lands on the edge
  always @(posedge clk)
  begin
    if (dataWrite)
      ram[dataAddress[9:2]] <= dataWriteData;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  // One LFSR step per stalled-mode cycle
  task automatic driveEnable(input logic stall);
    if (stall)
    begin
      lfsrState = lfsrNext(lfsrState);
      clkEnable <= lfsrState[0];
    end
    else
    begin
      clkEnable <= 1'b1;
    end
  endtask

  task automatic compareWord(input string signalName, input word_t actual,
                             input word_t expected);
    if (actual !== expected)
    begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", signalName, actual, expected);
      errorCount++;
    end
  endtask

  function automatic string testName(input int index);
    case (index)
      0:       return "alu and immediates";
      1:       return "shifts";
      2:       return "store and load";
      3:       return "branches and jumps";
      4:       return "multiply";
      default: return "branches and jumps with stalls";
    endcase
  endfunction

  // Program into ROM, zeros after it; RAM cleared
  task automatic loadProgram(input int testIndex);
    int base;
    base = testIndex * blockWords;
    for (int i = 0; i < memWords; i++)
    begin
      if (i < blockWords - 2)
        rom[i] = testData[base + 2 + i];
      else
        rom[i] = '0;
      ram[i] = '0;
    end
  endtask

  task automatic runTest(input int testIndex);
    word_t expectedV0;
    logic  stall;
    int    errorsBefore;
    expectedV0   = testData[testIndex * blockWords];
    stall        = testData[testIndex * blockWords + 1][0];
    errorsBefore = errorCount;
    @(negedge clk);
    loadProgram(testIndex);
    @(posedge clk);
    reset     <= 1'b1;
    clkEnable <= 1'b0;
    // Two edges with reset high
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    driveEnable(stall);
    @(negedge clk);
    while (active)
    begin
      @(posedge clk);
      driveEnable(stall);
      @(negedge clk);
    end
    compareWord("registerV0", registerV0, expectedV0);
    compareWord("instrAddress", instrAddress, `MIPS_HALT_ADDRESS);
    if (errorCount != errorsBefore)
      failedTests++;
    $display("Test %0d (%s): %s", testIndex + 1, testName(testIndex),
             (errorCount == errorsBefore) ? "ok" : "mismatch");
  endtask

  // Watchdog sized from the test count
  initial
  begin
    #(testCount * cyclesPerTest * clkPeriodNs);
    $display("Timeout: a program did not halt within %0d cycles per test", cyclesPerTest);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    reset       = 1'b1;
    clkEnable   = 1'b0;
    errorCount  = 0;
    failedTests = 0;
    lfsrState   = lfsrSeed;
    for (int i = 0; i < memWords; i++)
    begin
      rom[i] = '0;
      ram[i] = '0;
    end
    // Words the image leaves out stay zero
    for (int i = 0; i < testCount * blockWords; i++)
    begin
      testData[i] = '0;
    end
    $readmemh("test/cpu_testdata.hex", testData);
    for (int t = 0; t < testCount; t++)
    begin
      runTest(t);
    end
    compareWord("assertionFailures",
                u_mipsCpuHarvard.u_mipsCpuProperties.assertionFailures, '0);
    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             testCount, failedTests, errorCount);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- test/mipsCpuProperties.sv
// Concurrent checks on the core's top-level ports
// Bound to every mipsCpuHarvard instance
// Port checks are off while reset is high, except the reset check
// assertionFailures counts failures for the testbench summary

module mipsCpuProperties
  import mipsPkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  clkEnable,
  input logic  active,
  input word_t instrAddress,
  input logic  dataRead,
  input logic  dataWrite
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertionFailures;

  initial assertionFailures = 0;

  // One data access per cycle
  noReadAndWrite: assert property (@(posedge clk) disable iff (reset)
    !(dataRead && dataWrite))
    else
    begin
      $error("dataRead and dataWrite high together");
      assertionFailures++;
    end

  // Stalled edge leaves PC and active untouched
  holdWhenStalled: assert property (@(posedge clk) disable iff (reset)
    (!clkEnable && !reset) |=> ($stable(instrAddress) && $stable(active)))
    else
    begin
      $error("instrAddress or active changed while clkEnable was low");
      assertionFailures++;
    end

  // Halted core never writes memory
  noWriteWhenIdle: assert property (@(posedge clk) disable iff (reset)
    !active |-> !dataWrite)
    else
    begin
      $error("dataWrite high while active is low");
      assertionFailures++;
    end

  activeAfterReset: assert property (@(posedge clk) reset |=> active)
    else
    begin
      $error("active not set after reset");
      assertionFailures++;
    end

endmodule

bind mipsCpuHarvard mipsCpuProperties u_mipsCpuProperties (.*);

//--- src/mipsCpuHarvard.sv
// Single-cycle MIPS-I subset core, Harvard memory ports
// Both memories are external and read combinationally
// clkEnable low freezes all state, no other handshake
// Core stops once the PC reaches the halt address (jr $zero)

`include "mips_config.svh"

module mipsCpuHarvard
  import mipsPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clkEnable,
  output logic  active,
  output word_t registerV0,
  output word_t instrAddress,
  input  word_t instrReadData,
  output word_t dataAddress,
  output logic  dataWrite,
  output logic  dataRead,
  output word_t dataWriteData,
  input  word_t dataReadData
);

  controlSignals_t control;
  opcode_t         opcode;
  funct_t          funct;
  regIndex_t       rs;
  regIndex_t       rt;
  regIndex_t       rd;
  regIndex_t       writeIndex;
  logic [4:0]      shamt;
  logic [15:0]     immediate;
  logic [25:0]     jumpField;
  word_t           rsValue;
  word_t           rtValue;
  word_t           aluResult;
  word_t           writeData;
  word_t           pcPlusFour;
  logic            branchTaken;
  logic            atHalt;
  logic            running;
  logic            stepEnable;

  // Instruction fields
  assign opcode    = instrReadData[31:26];
  assign rs        = instrReadData[25:21];
  assign rt        = instrReadData[20:16];
  assign rd        = instrReadData[15:11];
  assign shamt     = instrReadData[10:6];
  assign funct     = instrReadData[5:0];
  assign immediate = instrReadData[15:0];
  assign jumpField = instrReadData[25:0];

  // Nothing retires at the halt address itself
  assign atHalt     = (instrAddress == `MIPS_HALT_ADDRESS);
  assign running    = active && !atHalt;
  assign stepEnable = clkEnable && running;

  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b1;
    else if (clkEnable && atHalt)
      active <= 1'b0;
  end

  controlUnit u_controlUnit (
    .opcode  (opcode),
    .funct   (funct),
    .control (control)
  );

  // Destination register
  always_comb
  begin
    case (control.regDest)
      regDestRd: writeIndex = rd;
      regDestRa: writeIndex = 5'd31;
      default:   writeIndex = rt;
    endcase
  end

  registerFile u_registerFile (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (control.regWrite && stepEnable),
    .readIndexA  (rs),
    .readIndexB  (rt),
    .writeIndex  (writeIndex),
    .writeData   (writeData),
    .readDataA   (rsValue),
    .readDataB   (rtValue),
    .registerV0  (registerV0)
  );

  executeUnit u_executeUnit (
    .clk         (clk),
    .reset       (reset),
    .enable      (stepEnable),
    .control     (control),
    .opcode      (opcode),
    .funct       (funct),
    .shamt       (shamt),
    .immediate   (immediate),
    .operandA    (rsValue),
    .operandB    (rtValue),
    .result      (aluResult),
    .branchTaken (branchTaken)
  );

  programCounter u_programCounter (
    .clk          (clk),
    .reset        (reset),
    .enable       (stepEnable),
    .control      (control),
    .branchTaken  (branchTaken),
    .immediate    (immediate),
    .jumpField    (jumpField),
    .jumpRegister (rsValue),
    .pc           (instrAddress),
    .pcPlusFour   (pcPlusFour)
  );

  // Write-back value
  always_comb
  begin
    case (control.writeBack)
      writeBackMem: writeData = dataReadData;
      writeBackPc4: writeData = pcPlusFour;
      default:      writeData = aluResult;
    endcase
  end

  // Data port, write only lands on an enabled edge
  assign dataAddress   = aluResult;
  assign dataWriteData = rtValue;
  assign dataRead      = control.memRead && running;
  assign dataWrite     = control.memWrite && stepEnable;

endmodule

//--- src/programCounter.sv
// Program counter with next-address selection
// No delay slot, the new PC applies to the very next instruction
// Priority is jr, then j/jal, then taken branch, then PC+4

`include "mips_config.svh"

module programCounter
  import mipsPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  controlSignals_t control,
  input  logic            branchTaken,
  input  logic [15:0]     immediate,
  input  logic [25:0]     jumpField,
  input  word_t           jumpRegister,
  output word_t           pc,
  output word_t           pcPlusFour
);

  word_t branchTarget;
  word_t jumpTarget;
  word_t nextPc;

  assign pcPlusFour   = pc + 32'd4;
  // Word offset relative to PC+4
  assign branchTarget = pcPlusFour + {{14{immediate[15]}}, immediate, 2'b00};
  // Stays within the current 256 MB region
  assign jumpTarget   = {pcPlusFour[31:28], jumpField, 2'b00};

  always_comb
  begin
    if (control.isJumpReg)
      nextPc = jumpRegister;
    else if (control.isJump)
      nextPc = jumpTarget;
    else if (branchTaken)
      nextPc = branchTarget;
    else
      nextPc = pcPlusFour;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= `MIPS_RESET_VECTOR;
    else if (enable)
      pc <= nextPc;
  end

endmodule

//--- src/executeUnit.sv
// Execute stage: ALU, shifter, compares, branch test and HI/LO
// Shifts use the shamt field only, no variable shifts
// HI/LO update on the enabled edge of mult or multu

module executeUnit
  import mipsPkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  controlSignals_t control,
  input  opcode_t         opcode,
  input  funct_t          funct,
  input  logic [4:0]      shamt,
  input  logic [15:0]     immediate,
  input  word_t           operandA,
  input  word_t           operandB,
  output word_t           result,
  output logic            branchTaken
);

  word_t       immExtended;
  word_t       aluOperandB;
  word_t       hi;
  word_t       lo;
  logic [63:0] product;

  // Second operand, register or extended immediate
  assign immExtended = control.zeroExtend ? {16'b0, immediate}
                                          : {{16{immediate[15]}}, immediate};
  assign aluOperandB = control.aluSrcImm ? immExtended : operandB;

  // beq/bne always compare the two registers
  assign branchTaken = control.isBranch &&
                       ((operandA == operandB) ^ control.branchOnNotEqual);

  // 64-bit product, operands widened by hand
  always_comb
  begin
    if (funct == fnMultu)
    begin
      product = {32'b0, operandA} * {32'b0, operandB};
    end
    else
    begin
      product = $signed({{32{operandA[31]}}, operandA}) *
                $signed({{32{operandB[31]}}, operandB});
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (enable && control.hiLoWrite)
    begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

  always_comb
  begin
    result = '0;
    if (opcode == opSpecial)
    begin
      case (funct)
        fnSll:  result = operandB << shamt;
        fnSrl:  result = operandB >> shamt;
        fnSra:  result = $signed(operandB) >>> shamt;
        fnAddu: result = operandA + aluOperandB;
        fnSubu: result = operandA - aluOperandB;
        fnAnd:  result = operandA & aluOperandB;
        fnOr:   result = operandA | aluOperandB;
        fnXor:  result = operandA ^ aluOperandB;
        fnSlt:  result = {31'b0, $signed(operandA) < $signed(aluOperandB)};
        fnSltu: result = {31'b0, operandA < aluOperandB};
        fnMfhi: result = hi;
        fnMflo: result = lo;
        default: result = '0;
      endcase
    end
    else
    begin
      case (opcode)
        // Also the effective address for lw/sw
        opAddiu, opLw, opSw: result = operandA + aluOperandB;
        opSlti:  result = {31'b0, $signed(operandA) < $signed(aluOperandB)};
        // sltiu still sign extends, then compares unsigned
        opSltiu: result = {31'b0, operandA < aluOperandB};
        opAndi:  result = operandA & aluOperandB;
        opOri:   result = operandA | aluOperandB;
        opXori:  result = operandA ^ aluOperandB;
        opLui:   result = {immediate, 16'b0};
        default: result = '0;
      endcase
    end
  end

endmodule

//--- src/registerFile.sv
// General purpose register file, 2 async reads and 1 sync write
// $zero is never written and always reads as zero
// Register 2 (v0) is brought out for result checking

`include "mips_config.svh"

module registerFile
  import mipsPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      writeEnable,
  input  regIndex_t readIndexA,
  input  regIndex_t readIndexB,
  input  regIndex_t writeIndex,
  input  word_t     writeData,
  output word_t     readDataA,
  output word_t     readDataB,
  output word_t     registerV0
);

  word_t registers [`MIPS_REG_COUNT];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++)
      begin
        registers[i] <= '0;
      end
    end
    else if (writeEnable && (writeIndex != '0))
    begin
      registers[writeIndex] <= writeData;
    end
  end

  // Async read, $zero forced
  assign readDataA  = (readIndexA == '0) ? '0 : registers[readIndexA];
  assign readDataB  = (readIndexB == '0) ? '0 : registers[readIndexB];
  assign registerV0 = registers[2];

endmodule

//--- src/controlUnit.sv
// Main decoder for the MIPS-I subset
// Unsupported opcode or funct values decode to an all-zero word
// ALU function itself is picked in the execute stage from opcode/funct

module controlUnit
  import mipsPkg::*;
(
  input  opcode_t         opcode,
  input  funct_t          funct,
  output controlSignals_t control
);

  always_comb
  begin
    // Default no-op
    control = '0;
    case (opcode)
      opSpecial:
      begin
        case (funct)
          fnSll, fnSrl, fnSra, fnAddu, fnSubu, fnAnd, fnOr, fnXor,
          fnSlt, fnSltu, fnMfhi, fnMflo:
          begin
            control.regWrite  = 1'b1;
            control.regDest   = regDestRd;
            control.writeBack = writeBackAlu;
          end
          fnJr:
          begin
            control.isJumpReg = 1'b1;
          end
          fnMult, fnMultu:
          begin
            control.hiLoWrite = 1'b1;
          end
          default:
          begin
            control = '0;
          end
        endcase
      end
      // Sign-extended immediate forms
      opAddiu, opSlti, opSltiu:
      begin
        control.regWrite  = 1'b1;
        control.regDest   = regDestRt;
        control.writeBack = writeBackAlu;
        control.aluSrcImm = 1'b1;
      end
      // Logical immediates zero extend, lui ignores the extension
      opAndi, opOri, opXori, opLui:
      begin
        control.regWrite   = 1'b1;
        control.regDest    = regDestRt;
        control.writeBack  = writeBackAlu;
        control.aluSrcImm  = 1'b1;
        control.zeroExtend = 1'b1;
      end
      opLw:
      begin
        control.regWrite  = 1'b1;
        control.memRead   = 1'b1;
        control.regDest   = regDestRt;
        control.writeBack = writeBackMem;
        control.aluSrcImm = 1'b1;
      end
      opSw:
      begin
        control.memWrite  = 1'b1;
        control.aluSrcImm = 1'b1;
      end
      opBeq:
      begin
        control.isBranch = 1'b1;
      end
      opBne:
      begin
        control.isBranch         = 1'b1;
        control.branchOnNotEqual = 1'b1;
      end
      opJ:
      begin
        control.isJump = 1'b1;
      end
      // Link goes to $ra
      opJal:
      begin
        control.isJump    = 1'b1;
        control.regWrite  = 1'b1;
        control.regDest   = regDestRa;
        control.writeBack = writeBackPc4;
      end
      default:
      begin
        control = '0;
      end
    endcase
  end

endmodule

//--- src/mipsPkg.sv
// Shared types and encodings for the MIPS-I subset core
// Only opcodes and funct codes of the supported subset are listed

package mipsPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIndex_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [1:0]  writeBackSel_t;
  typedef logic [1:0]  regDestSel_t;

  // Primary opcodes
  localparam opcode_t opSpecial = 6'h00;
  localparam opcode_t opJ       = 6'h02;
  localparam opcode_t opJal     = 6'h03;
  localparam opcode_t opBeq     = 6'h04;
  localparam opcode_t opBne     = 6'h05;
  localparam opcode_t opAddiu   = 6'h09;
  localparam opcode_t opSlti    = 6'h0A;
  localparam opcode_t opSltiu   = 6'h0B;
  localparam opcode_t opAndi    = 6'h0C;
  localparam opcode_t opOri     = 6'h0D;
  localparam opcode_t opXori    = 6'h0E;
  localparam opcode_t opLui     = 6'h0F;
  localparam opcode_t opLw      = 6'h23;
  localparam opcode_t opSw      = 6'h2B;

  // R-type function codes
  localparam funct_t fnSll   = 6'h00;
  localparam funct_t fnSrl   = 6'h02;
  localparam funct_t fnSra   = 6'h03;
  localparam funct_t fnJr    = 6'h08;
  localparam funct_t fnMfhi  = 6'h10;
  localparam funct_t fnMflo  = 6'h12;
  localparam funct_t fnMult  = 6'h18;
  localparam funct_t fnMultu = 6'h19;
  localparam funct_t fnAddu  = 6'h21;
  localparam funct_t fnSubu  = 6'h23;
  localparam funct_t fnAnd   = 6'h24;
  localparam funct_t fnOr    = 6'h25;
  localparam funct_t fnXor   = 6'h26;
  localparam funct_t fnSlt   = 6'h2A;
  localparam funct_t fnSltu  = 6'h2B;

  // Write-back sources
  localparam writeBackSel_t writeBackAlu = 2'd0;
  localparam writeBackSel_t writeBackMem = 2'd1;
  localparam writeBackSel_t writeBackPc4 = 2'd2;

  // Destination register choices
  localparam regDestSel_t regDestRt = 2'd0;
  localparam regDestSel_t regDestRd = 2'd1;
  localparam regDestSel_t regDestRa = 2'd2;

  // Decoded control word, all zero means no-op
  typedef struct packed {
    logic          regWrite;
    logic          memRead;
    logic          memWrite;
    regDestSel_t   regDest;
    writeBackSel_t writeBack;
    logic          aluSrcImm;
    logic          zeroExtend;
    logic          isBranch;
    logic          branchOnNotEqual;
    logic          isJump;
    logic          isJumpReg;
    logic          hiLoWrite;
  } controlSignals_t;

endpackage

//--- src/mips_config.svh
// Core-wide constants for the single-cycle MIPS core
// Reset vector follows the MIPS-I boot ROM convention
// Halt address zero is where a final jr $zero lands
// Register count must stay 32 for 5-bit register fields

`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// PC value loaded during reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// PC value that ends execution
`define MIPS_HALT_ADDRESS 32'h00000000

// General purpose registers
`define MIPS_REG_COUNT 32

`endif
